/* Makefile */
# Verilator build and run of the sample capture buffer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module buffer_tb -Mdir obj_dir
	./obj_dir/Vbuffer_tb | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
buffer_pkg.sv
buffer_ctrl_pkg.sv
buffer_regs.sv
capture_ctrl.sv
sample_banks.sv
readout_dma.sv
buffer.sv
buffer_tb.sv

/* buffer.sv */
// Sample capture buffer top level
// Registers, capture control, sample banks and readout engine
`timescale 1ns/1ns
module buffer (
  input  logic                                                          ps_clk,
  input  logic                                                          ps_reset,
  input  logic                                                          reg_write_i,
  input  logic [buffer_ctrl_pkg::REG_ADDR_WIDTH-1:0]                    reg_addr_i,
  input  logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0]                    reg_data_i,
  input  logic [buffer_pkg::CHANNELS-1:0]                               adc_valid_i,
  input  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic                                                          hw_start_i,
  input  logic                                                          hw_stop_i,
  output logic                                                          capture_full_o,
  output logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0]  write_depth_o,
  output logic                                                          write_depth_valid_o,
  output logic [buffer_pkg::SAMPLE_WIDTH-1:0]                           readout_data_o,
  output logic                                                          readout_valid_o,
  output logic                                                          readout_last_o,
  input  logic                                                          readout_ready_i
);

  logic arm;
  logic sw_start;
  logic sw_stop;
  logic capture_reset;
  logic readout_start;
  logic readout_reset;
  logic capture_idle;
  logic hold;
  logic [buffer_pkg::MODE_WIDTH-1:0] banking_mode;
  logic [buffer_pkg::CHANNELS-1:0] bank_write;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] write_count;
  logic [buffer_pkg::CHANNEL_WIDTH-1:0] read_channel;
  logic [buffer_pkg::DEPTH_WIDTH-1:0] read_index;
  logic [buffer_pkg::SAMPLE_WIDTH-1:0] read_data;

  buffer_regs regs_i (
    .ps_clk, .ps_reset, .reg_write_i, .reg_addr_i, .reg_data_i,
    .capture_idle_i(capture_idle),
    .arm_o(arm), .sw_start_o(sw_start), .sw_stop_o(sw_stop),
    .capture_reset_o(capture_reset),
    .readout_start_o(readout_start), .readout_reset_o(readout_reset),
    .banking_mode_o(banking_mode)
  );

  capture_ctrl capture_i (
    .ps_clk, .ps_reset,
    .arm_i(arm), .sw_start_i(sw_start), .sw_stop_i(sw_stop),
    .hw_start_i, .hw_stop_i,
    .capture_reset_i(capture_reset), .banking_mode_i(banking_mode), .adc_valid_i,
    .bank_write_o(bank_write), .write_count_o(write_count),
    .capture_idle_o(capture_idle), .hold_o(hold),
    .capture_full_o, .write_depth_o, .write_depth_valid_o
  );

  sample_banks banks_i (
    .ps_clk, .banking_mode_i(banking_mode),
    .bank_write_i(bank_write), .write_count_i(write_count), .adc_data_i,
    .read_channel_i(read_channel), .read_index_i(read_index), .read_data_o(read_data)
  );

  readout_dma dma_i (
    .ps_clk, .ps_reset,
    .readout_start_i(readout_start), .readout_reset_i(readout_reset),
    .hold_i(hold), .banking_mode_i(banking_mode),
    .write_depth_i(write_depth_o), .read_data_i(read_data),
    .read_channel_o(read_channel), .read_index_o(read_index),
    .readout_data_o, .readout_valid_o, .readout_last_o, .readout_ready_i
  );

endmodule

/* buffer_ctrl_pkg.sv */
// Sample buffer control definitions
// Register map, register word layout and the capture and readout state encodings
package buffer_ctrl_pkg;

  localparam int REG_ADDR_WIDTH = 2;
  localparam int REG_DATA_WIDTH = 8;

  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CONTROL = 2'd0;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BANKING = 2'd1;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_RESET = 2'd2;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_READOUT = 2'd3;

  // control view: arm in bit 2, start in bit 1, stop in bit 0
  // the reset word uses bit 0 for capture and bit 1 for readout,
  // and the readout word starts a transfer with bit 0
  typedef union packed {
    struct packed {
      logic [REG_DATA_WIDTH-4:0] unused;
      logic arm;
      logic start;
      logic stop;
    } ctrl;
    struct packed {
      logic [REG_DATA_WIDTH-buffer_pkg::MODE_WIDTH-1:0] unused;
      logic [buffer_pkg::MODE_WIDTH-1:0] mode;
    } bank;
  } cfg_word_u;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARMED,
    CAP_SAVING,
    CAP_HOLDING
  } capture_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_READING,
    RD_DONE
  } readout_state_e;

endpackage

/* buffer_pkg.sv */
// Sample buffer geometry
// Channel count, sample width and bank sizing shared by the capture and readout blocks
package buffer_pkg;

  localparam int CHANNELS = 4;
  localparam int SAMPLE_WIDTH = 16;

  // one bank per channel
  localparam int BANK_DEPTH = 16;
  localparam int TOTAL_DEPTH = CHANNELS * BANK_DEPTH;

  // a depth count must hold TOTAL_DEPTH itself
  localparam int DEPTH_WIDTH = $clog2(TOTAL_DEPTH + 1);
  localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);
  localparam int CHANNEL_WIDTH = $clog2(CHANNELS);

  // mode m activates the first 2^m channels
  localparam int MODE_WIDTH = 2;
  localparam int MAX_MODE = $clog2(CHANNELS);

endpackage

/* buffer_regs.sv */
// Sample buffer register block
// Turns register writes into one-cycle command strobes and keeps the banking mode
`timescale 1ns/1ns
module buffer_regs (
  input  logic                                        ps_clk,
  input  logic                                        ps_reset,
  input  logic                                        reg_write_i,
  input  logic [buffer_ctrl_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
  input  logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0]  reg_data_i,
  input  logic                                        capture_idle_i,
  output logic                                        arm_o,
  output logic                                        sw_start_o,
  output logic                                        sw_stop_o,
  output logic                                        capture_reset_o,
  output logic                                        readout_start_o,
  output logic                                        readout_reset_o,
  output logic [buffer_pkg::MODE_WIDTH-1:0]           banking_mode_o
);

  buffer_ctrl_pkg::cfg_word_u word;
  logic ctrl_wr;
  logic bank_wr;
  logic reset_wr;
  logic readout_wr;

  assign word = reg_data_i;

  assign ctrl_wr = reg_write_i && (reg_addr_i == buffer_ctrl_pkg::ADDR_CONTROL);
  assign bank_wr = reg_write_i && (reg_addr_i == buffer_ctrl_pkg::ADDR_BANKING);
  assign reset_wr = reg_write_i && (reg_addr_i == buffer_ctrl_pkg::ADDR_RESET);
  assign readout_wr = reg_write_i && (reg_addr_i == buffer_ctrl_pkg::ADDR_READOUT);

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      arm_o <= 1'b0;
      sw_start_o <= 1'b0;
      sw_stop_o <= 1'b0;
      capture_reset_o <= 1'b0;
      readout_start_o <= 1'b0;
      readout_reset_o <= 1'b0;
      banking_mode_o <= '0;
    end else begin
      arm_o <= ctrl_wr && word.ctrl.arm;
      sw_start_o <= ctrl_wr && word.ctrl.start;
      sw_stop_o <= ctrl_wr && word.ctrl.stop;
      // reset and readout words share the control bit positions
      capture_reset_o <= reset_wr && word.ctrl.stop;
      readout_reset_o <= reset_wr && word.ctrl.start;
      readout_start_o <= readout_wr && word.ctrl.stop;
      // mode changes only between captures, out of range values are dropped
      if (bank_wr && capture_idle_i && (word.bank.mode <= buffer_pkg::MAX_MODE)) begin
        banking_mode_o <= word.bank.mode;
      end
    end
  end

endmodule

/* buffer_tb.sv */
// Testbench for the sample capture buffer
// Directed tests against a cycle model of the capture FSM, with readout order checks
`timescale 1ns/1ns
module buffer_tb;

  logic ps_clk = 1'b0;
  logic ps_reset;
  logic reg_write_i;
  logic [buffer_ctrl_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i;
  logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0] reg_data_i;
  logic [buffer_pkg::CHANNELS-1:0] adc_valid_i = '0;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::SAMPLE_WIDTH-1:0] adc_data_i = '0;
  logic hw_start_i;
  logic hw_stop_i;
  logic capture_full_o;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] write_depth_o;
  logic write_depth_valid_o;
  logic [buffer_pkg::SAMPLE_WIDTH-1:0] readout_data_o;
  logic readout_valid_o;
  logic readout_last_o;
  logic readout_ready_i = 1'b1;

  int mismatches = 0;
  int timeouts = 0;
  bit ready_random = 1'b0;

  // observed at the DUT outputs
  int strobes = 0;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] strobe_depth;
  logic strobe_full;
  logic [buffer_pkg::SAMPLE_WIDTH-1:0] got_words[$];
  logic got_last[$];

  // reference model state
  buffer_ctrl_pkg::capture_state_e m_state;
  logic [buffer_pkg::MODE_WIDTH-1:0] m_mode;
  logic [buffer_pkg::SAMPLE_WIDTH-1:0] m_samples[buffer_pkg::CHANNELS][$];
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] m_depth;
  logic m_full;
  int m_strobes = 0;
  logic p_arm, p_start, p_stop, p_creset;

  buffer DUT (.*);

  initial begin
    forever #4 ps_clk = ~ps_clk;
  end

  // random ADC traffic and readout back-pressure
  initial begin
    logic [31:0] rnd;
    void'($urandom(62));
    forever begin
      @(negedge ps_clk);
      rnd = $urandom;
      adc_valid_i = rnd[buffer_pkg::CHANNELS-1:0];
      readout_ready_i = ready_random ? rnd[8] : 1'b1;
      for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
        rnd = $urandom;
        adc_data_i[c] = rnd[buffer_pkg::SAMPLE_WIDTH-1:0];
      end
    end
  end

  always @(posedge ps_clk) begin
    if (write_depth_valid_o) begin
      strobes++;
      strobe_depth = write_depth_o;
      strobe_full = capture_full_o;
    end
    if (readout_valid_o && readout_ready_i) begin
      got_words.push_back(readout_data_o);
      got_last.push_back(readout_last_o);
    end
  end

  // capture model that applies a register command one edge after sampling it
  always @(posedge ps_clk) begin
    buffer_ctrl_pkg::cfg_word_u w;
    int lim;
    logic hit;
    w = reg_data_i;
    lim = buffer_pkg::TOTAL_DEPTH >> m_mode;
    hit = 1'b0;
    if (ps_reset) begin
      m_state = buffer_ctrl_pkg::CAP_IDLE;
      m_mode = '0;
      m_full = 1'b0;
      {p_arm, p_start, p_stop, p_creset} = '0;
    end else begin
      if (reg_write_i && reg_addr_i == buffer_ctrl_pkg::ADDR_BANKING &&
          m_state == buffer_ctrl_pkg::CAP_IDLE && w.bank.mode <= 2'd2) begin
        m_mode = w.bank.mode;
      end
      if (p_creset) begin
        m_state = buffer_ctrl_pkg::CAP_IDLE;
        m_full = 1'b0;
      end else if (m_state == buffer_ctrl_pkg::CAP_SAVING) begin
        for (int c = 0; c < (1 << m_mode); c++) begin
          if (adc_valid_i[c]) begin
            m_samples[c].push_back(adc_data_i[c]);
            if (m_samples[c].size() == lim) hit = 1'b1;
          end
        end
        if (hit || p_stop || hw_stop_i) begin
          m_state = buffer_ctrl_pkg::CAP_HOLDING;
          m_full = hit;
          m_strobes++;
          for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
            m_depth[c] = (c < (1 << m_mode)) ?
                         buffer_pkg::DEPTH_WIDTH'(m_samples[c].size()) : '0;
          end
        end
      end else if (m_state != buffer_ctrl_pkg::CAP_HOLDING) begin
        if (p_start || (hw_start_i && m_state == buffer_ctrl_pkg::CAP_ARMED)) begin
          m_state = buffer_ctrl_pkg::CAP_SAVING;
          m_full = 1'b0;
          for (int c = 0; c < buffer_pkg::CHANNELS; c++) m_samples[c].delete();
        end else if (p_arm) begin
          m_state = buffer_ctrl_pkg::CAP_ARMED;
        end
      end
      p_arm = reg_write_i && reg_addr_i == buffer_ctrl_pkg::ADDR_CONTROL && reg_data_i[2];
      p_start = reg_write_i && reg_addr_i == buffer_ctrl_pkg::ADDR_CONTROL && reg_data_i[1];
      p_stop = reg_write_i && reg_addr_i == buffer_ctrl_pkg::ADDR_CONTROL && reg_data_i[0];
      p_creset = reg_write_i && reg_addr_i == buffer_ctrl_pkg::ADDR_RESET && reg_data_i[0];
    end
  end

  task automatic check_depth(input string name,
      input logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_word(input string name, input logic [buffer_pkg::SAMPLE_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name, input int got, exp);
    if (got != exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  function automatic logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0] ctrl_word(input logic arm,
      input logic start, input logic stop);
    buffer_ctrl_pkg::cfg_word_u w;
    w = '0;
    w.ctrl.arm = arm;
    w.ctrl.start = start;
    w.ctrl.stop = stop;
    return w;
  endfunction

  function automatic logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0] mode_word(
      input logic [buffer_pkg::MODE_WIDTH-1:0] mode);
    buffer_ctrl_pkg::cfg_word_u w;
    w = '0;
    w.bank.mode = mode;
    return w;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge ps_clk);
  endtask

  task automatic write_reg(input logic [buffer_ctrl_pkg::REG_ADDR_WIDTH-1:0] addr,
      input logic [buffer_ctrl_pkg::REG_DATA_WIDTH-1:0] data);
    @(negedge ps_clk);
    reg_write_i = 1'b1;
    reg_addr_i = addr;
    reg_data_i = data;
    @(negedge ps_clk);
    reg_write_i = 1'b0;
  endtask

  task automatic pulse_hw(input logic start, input logic stop);
    @(negedge ps_clk);
    hw_start_i = start;
    hw_stop_i = stop;
    @(negedge ps_clk);
    hw_start_i = 1'b0;
    hw_stop_i = 1'b0;
  endtask

  // waits for one more depth strobe, then compares it with the model
  task automatic check_capture(input int base);
    int n;
    n = 0;
    while (strobes <= base && n < 400) begin
      @(negedge ps_clk);
      n++;
    end
    if (strobes <= base) begin
      $display("timeout: no write-depth strobe after the capture ended");
      timeouts++;
    end
    idle(4);
    check_count("write_depth_valid_o pulses", strobes, m_strobes);
    check_depth("write_depth_o", strobe_depth, m_depth);
    check_bit("capture_full_o", strobe_full, m_full);
  endtask

  task automatic read_back();
    logic [buffer_pkg::SAMPLE_WIDTH-1:0] exp[$];
    int n;
    for (int c = 0; c < (1 << m_mode); c++) begin
      for (int i = 0; i < m_samples[c].size(); i++) exp.push_back(m_samples[c][i]);
    end
    got_words.delete();
    got_last.delete();
    ready_random = 1'b1;
    write_reg(buffer_ctrl_pkg::ADDR_READOUT, 8'h01);
    n = 0;
    while (!(got_last.size() > 0 && got_last[$]) && n < 2000) begin
      @(negedge ps_clk);
      n++;
    end
    if (!(got_last.size() > 0 && got_last[$])) begin
      $display("timeout: readout never delivered its last word");
      timeouts++;
    end
    ready_random = 1'b0;
    check_count("readout word count", got_words.size(), exp.size());
    for (int i = 0; i < got_words.size() && i < exp.size(); i++) begin
      check_word($sformatf("readout_data_o[%0d]", i), got_words[i], exp[i]);
      check_bit($sformatf("readout_last_o[%0d]", i), got_last[i], i == exp.size() - 1);
    end
  endtask

  task automatic sw_capture_modes();
    int base;
    for (int m = 0; m <= 2; m++) begin
      write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
      write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'(m)));
      base = strobes;
      write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
      idle(8);
      write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b0, 1'b1));
      check_capture(base);
      read_back();
    end
  endtask

  task automatic hw_start_stop();
    int base;
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'd1));
    base = strobes;
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b1, 1'b0, 1'b0));
    pulse_hw(1'b1, 1'b0);
    idle(8);
    pulse_hw(1'b0, 1'b1);
    check_capture(base);
    read_back();
    // start pin without arm must not leave IDLE
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    base = strobes;
    pulse_hw(1'b1, 1'b0);
    idle(8);
    pulse_hw(1'b0, 1'b1);
    idle(6);
    check_count("write_depth_valid_o pulses", strobes, base);
    got_words.delete();
    write_reg(buffer_ctrl_pkg::ADDR_READOUT, 8'h01);
    idle(20);
    check_count("readout word count", got_words.size(), 0);
    check_bit("readout_valid_o", readout_valid_o, 1'b0);
  endtask

  task automatic capture_until_full();
    int base;
    int deepest;
    for (int m = 0; m <= 2; m++) begin
      write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
      write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'(m)));
      base = strobes;
      write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
      check_capture(base);
      check_bit("capture_full_o", capture_full_o, 1'b1);
      deepest = 0;
      for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
        if (strobe_depth[c] > deepest) deepest = strobe_depth[c];
      end
      check_count("deepest write_depth_o", deepest, buffer_pkg::TOTAL_DEPTH >> m);
      read_back();
    end
  endtask

  task automatic capture_reset_states();
    int base;
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'd1));
    base = strobes;
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b1, 1'b0, 1'b0));
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    // no longer armed, so the start pin is ignored
    pulse_hw(1'b1, 1'b0);
    pulse_hw(1'b0, 1'b1);
    idle(4);
    check_count("write_depth_valid_o pulses", strobes, base);
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
    idle(5);
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    idle(4);
    check_count("write_depth_valid_o pulses", strobes, base);
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
    idle(4);
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b0, 1'b1));
    check_capture(base);
    base = strobes;
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    idle(4);
    check_count("write_depth_valid_o pulses", strobes, base);
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
    check_capture(base);
  endtask

  task automatic readout_reset_replay();
    int n;
    int kept;
    got_words.delete();
    got_last.delete();
    ready_random = 1'b1;
    write_reg(buffer_ctrl_pkg::ADDR_READOUT, 8'h01);
    n = 0;
    while (got_words.size() < 5 && n < 500) begin
      @(negedge ps_clk);
      n++;
    end
    if (got_words.size() < 5) begin
      $display("timeout: readout stalled before the readout reset");
      timeouts++;
    end
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h02);
    idle(2);
    kept = got_words.size();
    idle(30);
    check_count("words after readout reset", got_words.size(), kept);
    check_bit("readout_valid_o", readout_valid_o, 1'b0);
    read_back();
  endtask

  task automatic mode_change_in_saving();
    int base;
    write_reg(buffer_ctrl_pkg::ADDR_RESET, 8'h01);
    write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'd1));
    base = strobes;
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0));
    idle(4);
    write_reg(buffer_ctrl_pkg::ADDR_BANKING, mode_word(2'd2));
    idle(4);
    write_reg(buffer_ctrl_pkg::ADDR_CONTROL, ctrl_word(1'b0, 1'b0, 1'b1));
    check_capture(base);
    read_back();
  endtask

  initial begin
    ps_reset = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i = '0;
    reg_data_i = '0;
    hw_start_i = 1'b0;
    hw_stop_i = 1'b0;
    repeat (5) @(negedge ps_clk);
    ps_reset = 1'b0;
    sw_capture_modes();
    hw_start_stop();
    capture_until_full();
    capture_reset_states();
    readout_reset_replay();
    mode_change_in_saving();
    idle(4);
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* capture_ctrl.sv */
// Capture control for the sample buffer
// Runs the arm/start/stop FSM, counts samples per active channel,
// detects a full channel and reports the write depths once per capture
`timescale 1ns/1ns
module capture_ctrl (
  input  logic                                                           ps_clk,
  input  logic                                                           ps_reset,
  input  logic                                                           arm_i,
  input  logic                                                           sw_start_i,
  input  logic                                                           sw_stop_i,
  input  logic                                                           hw_start_i,
  input  logic                                                           hw_stop_i,
  input  logic                                                           capture_reset_i,
  input  logic [buffer_pkg::MODE_WIDTH-1:0]                              banking_mode_i,
  input  logic [buffer_pkg::CHANNELS-1:0]                                adc_valid_i,
  output logic [buffer_pkg::CHANNELS-1:0]                                bank_write_o,
  output logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0]   write_count_o,
  output logic                                                           capture_idle_o,
  output logic                                                           hold_o,
  output logic                                                           capture_full_o,
  output logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0]   write_depth_o,
  output logic                                                           write_depth_valid_o
);

  buffer_ctrl_pkg::capture_state_e state_q;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0] count_q;
  logic [buffer_pkg::CHANNEL_WIDTH:0] active_chans;
  logic [buffer_pkg::DEPTH_WIDTH-1:0] limit;
  logic start_ok;
  logic stop_ok;
  logic full_hit;

  assign active_chans = (buffer_pkg::CHANNEL_WIDTH + 1)'(1) << banking_mode_i;
  // chained banks give each active channel a deeper record
  assign limit = buffer_pkg::DEPTH_WIDTH'(buffer_pkg::TOTAL_DEPTH >> banking_mode_i);

  // hardware start only counts while armed
  assign start_ok = (sw_start_i && (state_q == buffer_ctrl_pkg::CAP_IDLE ||
                                    state_q == buffer_ctrl_pkg::CAP_ARMED)) ||
                    (hw_start_i && state_q == buffer_ctrl_pkg::CAP_ARMED);
  assign stop_ok = sw_stop_i || hw_stop_i;

  assign write_count_o = count_q;
  assign capture_idle_o = (state_q == buffer_ctrl_pkg::CAP_IDLE);
  assign hold_o = (state_q == buffer_ctrl_pkg::CAP_HOLDING);

  always_comb begin
    full_hit = 1'b0;
    for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
      bank_write_o[c] = (state_q == buffer_ctrl_pkg::CAP_SAVING) && adc_valid_i[c] &&
                        (c < active_chans);
      // the write landing on the last free slot ends the capture
      if (bank_write_o[c] && (count_q[c] == limit - 1'b1)) begin
        full_hit = 1'b1;
      end
      write_depth_o[c] = (c < active_chans) ? count_q[c] : '0;
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset || capture_reset_i) begin
      state_q <= buffer_ctrl_pkg::CAP_IDLE;
      count_q <= '0;
      capture_full_o <= 1'b0;
      write_depth_valid_o <= 1'b0;
    end else begin
      write_depth_valid_o <= 1'b0;
      case (state_q)
        buffer_ctrl_pkg::CAP_IDLE, buffer_ctrl_pkg::CAP_ARMED: begin
          if (start_ok) begin
            state_q <= buffer_ctrl_pkg::CAP_SAVING;
            count_q <= '0;
            capture_full_o <= 1'b0;
          end else if (arm_i) begin
            state_q <= buffer_ctrl_pkg::CAP_ARMED;
          end
        end
        buffer_ctrl_pkg::CAP_SAVING: begin
          for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
            if (bank_write_o[c]) begin
              count_q[c] <= count_q[c] + 1'b1;
            end
          end
          if (stop_ok || full_hit) begin
            state_q <= buffer_ctrl_pkg::CAP_HOLDING;
            capture_full_o <= full_hit;
            write_depth_valid_o <= 1'b1;
          end
        end
        default: begin
          // holding until a capture reset
          state_q <= state_q;
        end
      endcase
    end
  end

endmodule

/* readout_dma.sv */
// Readout engine for the sample buffer
// Walks each active channel up to its write depth and streams the samples
// out with valid/ready/last, one outstanding bank read at a time
`timescale 1ns/1ns
module readout_dma (
  input  logic                                                          ps_clk,
  input  logic                                                          ps_reset,
  input  logic                                                          readout_start_i,
  input  logic                                                          readout_reset_i,
  input  logic                                                          hold_i,
  input  logic [buffer_pkg::MODE_WIDTH-1:0]                             banking_mode_i,
  input  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0]  write_depth_i,
  input  logic [buffer_pkg::SAMPLE_WIDTH-1:0]                           read_data_i,
  output logic [buffer_pkg::CHANNEL_WIDTH-1:0]                          read_channel_o,
  output logic [buffer_pkg::DEPTH_WIDTH-1:0]                            read_index_o,
  output logic [buffer_pkg::SAMPLE_WIDTH-1:0]                           readout_data_o,
  output logic                                                          readout_valid_o,
  output logic                                                          readout_last_o,
  input  logic                                                          readout_ready_i
);

  buffer_ctrl_pkg::readout_state_e state_q;
  logic [buffer_pkg::CHANNEL_WIDTH-1:0] chan_q;
  logic [buffer_pkg::DEPTH_WIDTH-1:0] idx_q;
  logic fetch_q;
  logic [buffer_pkg::CHANNEL_WIDTH:0] active_chans;
  logic later_words;
  logic last_word;

  assign read_channel_o = chan_q;
  assign read_index_o = idx_q;
  assign active_chans = (buffer_pkg::CHANNEL_WIDTH + 1)'(1) << banking_mode_i;

  // any samples left in a later active channel
  always_comb begin
    later_words = 1'b0;
    for (int c = 0; c < buffer_pkg::CHANNELS; c++) begin
      if ((c > chan_q) && (c < active_chans) && (write_depth_i[c] != '0)) begin
        later_words = 1'b1;
      end
    end
  end

  assign last_word = (idx_q + 1'b1 == write_depth_i[chan_q]) && !later_words;

  always_ff @(posedge ps_clk) begin
    if (ps_reset || readout_reset_i) begin
      state_q <= buffer_ctrl_pkg::RD_IDLE;
      fetch_q <= 1'b0;
      readout_valid_o <= 1'b0;
      readout_last_o <= 1'b0;
    end else begin
      case (state_q)
        buffer_ctrl_pkg::RD_IDLE: begin
          if (readout_start_i && hold_i && (|write_depth_i)) begin
            state_q <= buffer_ctrl_pkg::RD_READING;
            chan_q <= '0;
            idx_q <= '0;
          end
        end
        buffer_ctrl_pkg::RD_READING: begin
          if (readout_valid_o) begin
            if (readout_ready_i) begin
              readout_valid_o <= 1'b0;
            end
          end else if (fetch_q) begin
            // bank data for chan_q/idx_q arrived this cycle
            fetch_q <= 1'b0;
            readout_data_o <= read_data_i;
            readout_valid_o <= 1'b1;
            readout_last_o <= last_word;
            idx_q <= idx_q + 1'b1;
            if (last_word) begin
              state_q <= buffer_ctrl_pkg::RD_DONE;
            end
          end else if (idx_q < write_depth_i[chan_q]) begin
            fetch_q <= 1'b1;
          end else begin
            // channel exhausted or empty
            chan_q <= chan_q + 1'b1;
            idx_q <= '0;
          end
        end
        default: begin
          if (readout_ready_i) begin
            state_q <= buffer_ctrl_pkg::RD_IDLE;
            readout_valid_o <= 1'b0;
            readout_last_o <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

/* sample_banks.sv */
// Sample memory banks
// One memory per channel; idle channels lend their banks to the active ones
// so sample k of channel c lands in bank c + 2^mode * (k / BANK_DEPTH)
`timescale 1ns/1ns
module sample_banks (
  input  logic                                                          ps_clk,
  input  logic [buffer_pkg::MODE_WIDTH-1:0]                             banking_mode_i,
  input  logic [buffer_pkg::CHANNELS-1:0]                               bank_write_i,
  input  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::DEPTH_WIDTH-1:0]  write_count_i,
  input  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic [buffer_pkg::CHANNEL_WIDTH-1:0]                          read_channel_i,
  input  logic [buffer_pkg::DEPTH_WIDTH-1:0]                            read_index_i,
  output logic [buffer_pkg::SAMPLE_WIDTH-1:0]                           read_data_o
);

  localparam int SEG_W = buffer_pkg::DEPTH_WIDTH - buffer_pkg::BANK_ADDR_WIDTH;

  logic [buffer_pkg::SAMPLE_WIDTH-1:0] mem [buffer_pkg::CHANNELS][buffer_pkg::BANK_DEPTH];

  logic [buffer_pkg::CHANNEL_WIDTH-1:0] mode_mask;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::CHANNEL_WIDTH-1:0] bank_owner;
  logic [buffer_pkg::CHANNELS-1:0] bank_we;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::BANK_ADDR_WIDTH-1:0] bank_waddr;
  logic [buffer_pkg::CHANNELS-1:0][buffer_pkg::SAMPLE_WIDTH-1:0] bank_wdata;
  logic [SEG_W-1:0] read_seg;
  logic [buffer_pkg::CHANNEL_WIDTH-1:0] read_bank;

  assign mode_mask = buffer_pkg::CHANNEL_WIDTH'((1 << banking_mode_i) - 1);

  // each bank belongs to one active channel and one segment of its record
  always_comb begin
    for (int b = 0; b < buffer_pkg::CHANNELS; b++) begin
      bank_owner[b] = buffer_pkg::CHANNEL_WIDTH'(b) & mode_mask;
      bank_we[b] = bank_write_i[bank_owner[b]] &&
                   (write_count_i[bank_owner[b]][buffer_pkg::DEPTH_WIDTH-1:buffer_pkg::BANK_ADDR_WIDTH]
                    == SEG_W'(b >> banking_mode_i));
      bank_waddr[b] = write_count_i[bank_owner[b]][buffer_pkg::BANK_ADDR_WIDTH-1:0];
      bank_wdata[b] = adc_data_i[bank_owner[b]];
    end
  end

  assign read_seg = read_index_i[buffer_pkg::DEPTH_WIDTH-1:buffer_pkg::BANK_ADDR_WIDTH];
  assign read_bank = read_channel_i + buffer_pkg::CHANNEL_WIDTH'(read_seg << banking_mode_i);

  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < buffer_pkg::CHANNELS; b++) begin
      if (bank_we[b]) begin
        mem[b][bank_waddr[b]] <= bank_wdata[b];
      end
    end
    read_data_o <= mem[read_bank][read_index_i[buffer_pkg::BANK_ADDR_WIDTH-1:0]];
  end

endmodule
